//--- filelist.f
uart_bridge_pkg.sv
uart_link_ctrl.sv
cmd_frame_gen.sv
bus_credit_port.sv
param_frame_parser.sv
uart_bridge_top.sv
tb_uart_bridge.sv

//--- Bender.yml
package:
  name: uart_bridge

sources:
  - uart_bridge_pkg.sv
  - uart_link_ctrl.sv
  - cmd_frame_gen.sv
  - bus_credit_port.sv
  - param_frame_parser.sv
  - uart_bridge_top.sv
  - target: test
    files:
      - tb_uart_bridge.sv

//--- tb_uart_bridge.sv
module tb_uart_bridge;
	import uart_bridge_pkg::*;

	typedef enum logic [2:0] {
		STEP_SET,
		STEP_READ,
		STEP_RX,
		STEP_HOLD,
		STEP_BUSY
	} step_kind_t;

	typedef struct packed {
		step_kind_t kind;
		word_t      data;
		logic [3:0] n_tx;
		logic [1:0] n_up;
	} step_t;

	logic       AXI_CLK;
	logic       axi_arstn;
	logic       download_valid;
	reg_index_t download_index;
	word_t      download_data;
	logic       uart_irq;
	logic       req_valid;
	bus_req_t   req;
	logic       credit_return;
	logic       rsp_valid;
	word_t      rsp_data;
	logic       upload_valid;
	reg_index_t upload_index;
	word_t      upload_data;

	step_t       steps [0:7];
	byte_t       rx_q [$];
	byte_t       tx_q [$];
	byte_t       exp_tx_q [$];
	reg_index_t  up_idx_q [$];
	word_t       up_data_q [$];
	reg_index_t  exp_idx_q [$];
	word_t       exp_data_q [$];
	word_t       rsp_q [$];
	int unsigned rsp_due_q [$];
	int unsigned credit_due_q [$];
	int unsigned cyc;
	int unsigned last_rsp_due;
	int unsigned last_credit_due;
	int          outstanding;
	int          errors;
	int          checks;
	logic        tx_full;
	logic        first_seen;
	logic        timed_out;

	uart_bridge_top uart_bridge_top_i (.*);

	initial begin
		AXI_CLK = 1'b0;
		forever #10 AXI_CLK = ~AXI_CLK;
	end

	// --------------------
	// UART and credit model
	// --------------------
	task automatic serve_request();
		word_t       rd;
		int unsigned due;
		outstanding++;
		checks++;
		if (outstanding > CREDIT_MAX) begin
			$display("ERROR t=%0t outstanding requests: got %0d expected at most %0d",
				$time, outstanding, CREDIT_MAX);
			errors++;
		end
		// Credits come back in order after a random delay
		due = cyc + $urandom_range(1, 6);
		if (due <= last_credit_due)
			due = last_credit_due + 1;
		last_credit_due = due;
		credit_due_q.push_back(due);
		if (!first_seen) begin
			first_seen = 1'b1;
			checks++;
			if (!req.is_write || req.addr != 4'hc || req.data != 32'h13) begin
				$display("ERROR t=%0t req: got %h expected %h", $time, req,
					{1'b1, 4'hc, 32'h13});
				errors++;
			end
		end
		if (req.is_write) begin
			if (req.addr == 4'h4) begin
				if (tx_full) begin
					$display("TX_REG was written at t=%0t while status reported a full FIFO",
						$time);
					errors++;
				end
				tx_q.push_back(req.data[7:0]);
			end
		end else begin
			rd = '0;
			if (req.addr == 4'h8) begin
				rd[0] = rx_q.size() != 0;
				rd[3] = tx_full;
			end else if (rx_q.size() != 0) begin
				rd = word_t'(rx_q.pop_front());
			end
			due = cyc + $urandom_range(1, 4);
			if (due <= last_rsp_due)
				due = last_rsp_due + 1;
			last_rsp_due = due;
			rsp_due_q.push_back(due);
			rsp_q.push_back(rd);
		end
	endtask

	always @(negedge AXI_CLK) begin
		cyc++;
		rsp_valid     = 1'b0;
		credit_return = 1'b0;
		if (!axi_arstn) begin
			checks++;
			if (req_valid !== 1'b0) begin
				$display("ERROR t=%0t req_valid: got %b expected 0", $time, req_valid);
				errors++;
			end
		end else begin
			if (req_valid)
				serve_request();
			if (upload_valid) begin
				up_idx_q.push_back(upload_index);
				up_data_q.push_back(upload_data);
			end
			if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
				rsp_valid = 1'b1;
				rsp_data  = rsp_q.pop_front();
				void'(rsp_due_q.pop_front());
			end
			if (credit_due_q.size() != 0 && credit_due_q[0] <= cyc) begin
				credit_return = 1'b1;
				outstanding--;
				void'(credit_due_q.pop_front());
			end
			uart_irq = rx_q.size() != 0;
		end
	end

	// --------------------
	// Expected frames
	// --------------------
	function automatic void expect_set_frame(input word_t p);
		logic [71:0] frame;
		byte_t       sum;
		int          i;
		frame = {8'hEF, 8'hEF, 8'h07, 8'hFF, 8'h40, p};
		sum   = '0;
		for (i = 8; i >= 0; i--) begin
			exp_tx_q.push_back(frame[i*8 +: 8]);
			sum = sum + frame[i*8 +: 8];
		end
		exp_tx_q.push_back(sum);
	endfunction

	function automatic void expect_read_frame();
		logic [47:0] frame;
		int          i;
		frame = {8'hEF, 8'hEF, 8'h03, 8'hFF, 8'h00, 8'hE0};
		for (i = 5; i >= 0; i--)
			exp_tx_q.push_back(frame[i*8 +: 8]);
	endfunction

	// Noise, then a header, then 31 payload bytes
	task automatic inject_frame(input byte_t type_byte);
		byte_t pl [0:30];
		int    i;
		rx_q.push_back(8'h3C);
		rx_q.push_back(8'hED);
		rx_q.push_back(8'h41);
		rx_q.push_back(8'hED);
		rx_q.push_back(8'hFA);
		rx_q.push_back(type_byte);
		for (i = 0; i < 31; i++) begin
			pl[i] = byte_t'($urandom);
			if (pl[i] == 8'hED)
				pl[i] = 8'h12;
			rx_q.push_back(pl[i]);
		end
		if (type_byte == 8'h39) begin
			exp_idx_q.push_back(4'd1);
			exp_data_q.push_back({16'h0, pl[8], pl[9]});
			exp_idx_q.push_back(4'd2);
			exp_data_q.push_back({16'h0, pl[10], pl[11]});
			exp_idx_q.push_back(4'd3);
			exp_data_q.push_back({16'h0, pl[28], pl[29]});
		end
	endtask

	task automatic host_write(input reg_index_t index, input word_t data);
		@(negedge AXI_CLK);
		download_valid = 1'b1;
		download_index = index;
		download_data  = data;
		@(negedge AXI_CLK);
		download_valid = 1'b0;
	endtask

	task automatic wait_done(input int idx, input int n_tx, input int n_up);
		int cnt;
		cnt = 0;
		while ((tx_q.size() < n_tx || up_idx_q.size() < n_up || rx_q.size() != 0) &&
			cnt < 3000) begin
			@(negedge AXI_CLK);
			cnt++;
		end
		if (tx_q.size() < n_tx || up_idx_q.size() < n_up || rx_q.size() != 0) begin
			$display("Step %0d did not finish within %0d cycles", idx, cnt);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic compare_results(input int idx);
		int i;
		checks++;
		if (tx_q.size() != exp_tx_q.size() || up_idx_q.size() != exp_idx_q.size()) begin
			$display("ERROR t=%0t step %0d tx/upload count: got %0d/%0d expected %0d/%0d",
				$time, idx, tx_q.size(), up_idx_q.size(), exp_tx_q.size(), exp_idx_q.size());
			errors++;
		end
		for (i = 0; i < tx_q.size() && i < exp_tx_q.size(); i++) begin
			checks++;
			if (tx_q[i] != exp_tx_q[i]) begin
				$display("ERROR t=%0t tx_byte[%0d]: got %h expected %h",
					$time, i, tx_q[i], exp_tx_q[i]);
				errors++;
			end
		end
		for (i = 0; i < up_idx_q.size() && i < exp_idx_q.size(); i++) begin
			checks++;
			if (up_idx_q[i] != exp_idx_q[i] || up_data_q[i] != exp_data_q[i]) begin
				$display("ERROR t=%0t upload[%0d] index/data: got %0d/%h expected %0d/%h",
					$time, i, up_idx_q[i], up_data_q[i], exp_idx_q[i], exp_data_q[i]);
				errors++;
			end
		end
		tx_q.delete();
		exp_tx_q.delete();
		up_idx_q.delete();
		up_data_q.delete();
		exp_idx_q.delete();
		exp_data_q.delete();
	endtask

	// --------------------
	// Step sequencer
	// --------------------
	task automatic run_step(input int idx);
		step_t s;
		s = steps[idx];
		case (s.kind)
			STEP_SET: begin
				host_write(4'd1, s.data);
				expect_set_frame(s.data);
			end
			STEP_READ: begin
				host_write(4'd2, s.data);
				if (s.data == 32'hAAAA_AAAA)
					expect_read_frame();
			end
			STEP_RX: begin
				@(negedge AXI_CLK);
				inject_frame(s.data[7:0]);
			end
			STEP_HOLD: begin
				tx_full = 1'b1;
				host_write(4'd1, s.data);
				repeat (40) @(negedge AXI_CLK);
				tx_full = 1'b0;
				expect_set_frame(s.data);
			end
			default: begin
				// Second command lands while the first is still pending
				host_write(4'd1, s.data);
				repeat (3) @(negedge AXI_CLK);
				host_write(4'd2, 32'hAAAA_AAAA);
				expect_set_frame(s.data);
			end
		endcase
		wait_done(idx, s.n_tx, s.n_up);
		repeat (60) @(negedge AXI_CLK);
		compare_results(idx);
	endtask

	initial begin : main_flow
		int i;
		int cnt;
		void'($urandom(32'h7e92844f));
		axi_arstn       = 1'b0;
		download_valid  = 1'b0;
		download_index  = '0;
		download_data   = '0;
		uart_irq        = 1'b0;
		credit_return   = 1'b0;
		rsp_valid       = 1'b0;
		rsp_data        = '0;
		cyc             = 0;
		last_rsp_due    = 0;
		last_credit_due = 0;
		outstanding     = 0;
		errors          = 0;
		checks          = 0;
		tx_full         = 1'b0;
		first_seen      = 1'b0;
		timed_out       = 1'b0;

		steps[0] = {STEP_SET,  32'h1234_5678, 4'd10, 2'd0};
		steps[1] = {STEP_READ, 32'hAAAA_AAAA, 4'd6,  2'd0};
		steps[2] = {STEP_READ, 32'hAAAA_AAAB, 4'd0,  2'd0};
		steps[3] = {STEP_RX,   32'h0000_0039, 4'd0,  2'd3};
		steps[4] = {STEP_RX,   32'h0000_003A, 4'd0,  2'd0};
		steps[5] = {STEP_HOLD, 32'hCAFE_0042, 4'd10, 2'd0};
		steps[6] = {STEP_BUSY, 32'h8000_00FF, 4'd10, 2'd0};
		steps[7] = {STEP_RX,   32'h0000_0039, 4'd0,  2'd3};

		// Three rising edges under reset, release on the next falling edge
		repeat (3) @(posedge AXI_CLK);
		@(negedge AXI_CLK);
		axi_arstn = 1'b1;

		cnt = 0;
		while (!first_seen && cnt < 100) begin
			@(negedge AXI_CLK);
			cnt++;
		end
		if (!first_seen) begin
			$display("No bus request appeared after reset");
			errors++;
			timed_out = 1'b1;
		end

		for (i = 0; i < 8 && !timed_out; i++)
			run_step(i);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- uart_bridge_top.sv
module uart_bridge_top (
	input  logic                         AXI_CLK,
	input  logic                         axi_arstn,
	input  logic                         download_valid,
	input  uart_bridge_pkg::reg_index_t  download_index,
	input  uart_bridge_pkg::word_t       download_data,
	input  logic                         uart_irq,
	output logic                         req_valid,
	output uart_bridge_pkg::bus_req_t    req,
	input  logic                         credit_return,
	input  logic                         rsp_valid,
	input  uart_bridge_pkg::word_t       rsp_data,
	output logic                         upload_valid,
	output uart_bridge_pkg::reg_index_t  upload_index,
	output uart_bridge_pkg::word_t       upload_data
);
	import uart_bridge_pkg::*;

	logic      issue;
	bus_req_t  issue_req;
	logic      can_issue;
	logic      frame_start;
	cmd_kind_t frame_kind;
	word_t     frame_param;
	logic      byte_next;
	byte_t     cur_byte;
	logic      last;
	logic      rx_byte_valid;
	byte_t     rx_byte;

	uart_link_ctrl uart_link_ctrl_i (
		.AXI_CLK        (AXI_CLK),
		.axi_arstn      (axi_arstn),
		.download_valid (download_valid),
		.download_index (download_index),
		.download_data  (download_data),
		.uart_irq       (uart_irq),
		.issue          (issue),
		.issue_req      (issue_req),
		.can_issue      (can_issue),
		.rsp_valid      (rsp_valid),
		.rsp_data       (rsp_data),
		.frame_start    (frame_start),
		.frame_kind     (frame_kind),
		.frame_param    (frame_param),
		.byte_next      (byte_next),
		.cur_byte       (cur_byte),
		.last           (last),
		.rx_byte_valid  (rx_byte_valid),
		.rx_byte        (rx_byte)
	);

	cmd_frame_gen cmd_frame_gen_i (
		.AXI_CLK     (AXI_CLK),
		.axi_arstn   (axi_arstn),
		.frame_start (frame_start),
		.frame_kind  (frame_kind),
		.frame_param (frame_param),
		.byte_next   (byte_next),
		.cur_byte    (cur_byte),
		.last        (last)
	);

	bus_credit_port bus_credit_port_i (
		.AXI_CLK       (AXI_CLK),
		.axi_arstn     (axi_arstn),
		.issue         (issue),
		.issue_req     (issue_req),
		.can_issue     (can_issue),
		.req_valid     (req_valid),
		.req           (req),
		.credit_return (credit_return)
	);

	param_frame_parser param_frame_parser_i (
		.AXI_CLK       (AXI_CLK),
		.axi_arstn     (axi_arstn),
		.rx_byte_valid (rx_byte_valid),
		.rx_byte       (rx_byte),
		.upload_valid  (upload_valid),
		.upload_index  (upload_index),
		.upload_data   (upload_data)
	);

endmodule

//--- param_frame_parser.sv
module param_frame_parser (
	input  logic                         AXI_CLK,
	input  logic                         axi_arstn,
	input  logic                         rx_byte_valid,
	input  uart_bridge_pkg::byte_t       rx_byte,
	output logic                         upload_valid,
	output uart_bridge_pkg::reg_index_t  upload_index,
	output uart_bridge_pkg::word_t       upload_data
);
	import uart_bridge_pkg::*;

	parse_state_t state;
	byte_t        pos;
	byte_t        hi_byte;
	param_t       param_val;
	logic         up_hit;
	reg_index_t   up_index;

	// --------------------
	// Header search
	// --------------------
	always_ff @(posedge AXI_CLK or negedge axi_arstn) begin
		if (!axi_arstn) begin
			state <= PARSE_HUNT;
			pos   <= '0;
		end else if (rx_byte_valid) begin
			case (state)
				PARSE_HUNT: begin
					if (rx_byte == FRAME_SYNC0)
						state <= PARSE_SYNC;
				end
				PARSE_SYNC: begin
					// A repeated first sync byte may still start a frame
					if (rx_byte == FRAME_SYNC1)
						state <= PARSE_TYPE;
					else if (rx_byte != FRAME_SYNC0)
						state <= PARSE_HUNT;
				end
				PARSE_TYPE: begin
					pos   <= '0;
					state <= (rx_byte == FRAME_PARAM_TYPE) ? PARSE_PAYLOAD : PARSE_HUNT;
				end
				PARSE_PAYLOAD: begin
					pos <= pos + 8'd1;
					if (pos == PAYLOAD_LAST)
						state <= PARSE_HUNT;
				end
				default: state <= PARSE_HUNT;
			endcase
		end
	end

	// Previous payload byte is the high half at each low position
	always_ff @(posedge AXI_CLK) begin
		if (rx_byte_valid && state == PARSE_PAYLOAD)
			hi_byte <= rx_byte;
	end

	assign param_val = {hi_byte, rx_byte};

	always_comb begin
		up_hit   = 1'b0;
		up_index = UP_RAMAN1;
		if (rx_byte_valid && state == PARSE_PAYLOAD) begin
			case (pos)
				RAMAN1_POS + 8'd1: begin
					up_hit   = 1'b1;
					up_index = UP_RAMAN1;
				end
				RAMAN2_POS + 8'd1: begin
					up_hit   = 1'b1;
					up_index = UP_RAMAN2;
				end
				EDFA_POS + 8'd1: begin
					up_hit   = 1'b1;
					up_index = UP_EDFA;
				end
				default: ;
			endcase
		end
	end

	// --------------------
	// Upload
	// --------------------
	always_ff @(posedge AXI_CLK or negedge axi_arstn) begin
		if (!axi_arstn)
			upload_valid <= 1'b0;
		else
			upload_valid <= up_hit;
	end

	always_ff @(posedge AXI_CLK) begin
		if (up_hit) begin
			upload_index <= up_index;
			upload_data  <= word_t'(param_val);
		end
	end

	a_upload_in_payload: assert property (@(posedge AXI_CLK) disable iff (!axi_arstn)
		upload_valid |-> state == PARSE_PAYLOAD);

endmodule

//--- bus_credit_port.sv
module bus_credit_port (
	input  logic                       AXI_CLK,
	input  logic                       axi_arstn,
	input  logic                       issue,
	input  uart_bridge_pkg::bus_req_t  issue_req,
	output logic                       can_issue,
	output logic                       req_valid,
	output uart_bridge_pkg::bus_req_t  req,
	input  logic                       credit_return
);
	import uart_bridge_pkg::*;

	credit_t credits;
	logic    take;

	assign can_issue = credits != '0;
	assign take      = issue & can_issue;

	// Take and return in the same cycle cancel out
	always_ff @(posedge AXI_CLK or negedge axi_arstn) begin
		if (!axi_arstn) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({take, credit_return})
				2'b10:   credits <= credits - 2'd1;
				2'b01:   credits <= credits + 2'd1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge AXI_CLK or negedge axi_arstn) begin
		if (!axi_arstn)
			req_valid <= 1'b0;
		else
			req_valid <= take;
	end

	always_ff @(posedge AXI_CLK) begin
		if (take)
			req <= issue_req;
	end

	// A return with all credits home means the master miscounted
	a_no_overflow: assert property (@(posedge AXI_CLK) disable iff (!axi_arstn)
		credit_return |-> (credits < CREDIT_MAX || take));

	// A wrapped counter also lands above the maximum
	a_credit_range: assert property (@(posedge AXI_CLK) disable iff (!axi_arstn)
		credits <= CREDIT_MAX);

endmodule

//--- cmd_frame_gen.sv
module cmd_frame_gen (
	input  logic                        AXI_CLK,
	input  logic                        axi_arstn,
	input  logic                        frame_start,
	input  uart_bridge_pkg::cmd_kind_t  frame_kind,
	input  uart_bridge_pkg::word_t      frame_param,
	input  logic                        byte_next,
	output uart_bridge_pkg::byte_t      cur_byte,
	output logic                        last
);
	import uart_bridge_pkg::*;

	logic [3:0] byte_idx;
	cmd_kind_t  kind_q;
	word_t      param_q;
	byte_t      sum;

	always_ff @(posedge AXI_CLK or negedge axi_arstn) begin
		if (!axi_arstn) begin
			byte_idx <= '0;
			kind_q   <= CMD_READ;
		end else if (frame_start) begin
			byte_idx <= '0;
			kind_q   <= frame_kind;
		end else if (byte_next) begin
			byte_idx <= byte_idx + 4'd1;
		end
	end

	// Running checksum over the bytes already sent
	always_ff @(posedge AXI_CLK) begin
		if (frame_start) begin
			param_q <= frame_param;
			sum     <= '0;
		end else if (byte_next) begin
			sum <= sum + cur_byte;
		end
	end

	always_comb begin
		cur_byte = CMD_HEAD;
		if (kind_q == CMD_SET) begin
			case (byte_idx)
				4'd0, 4'd1: cur_byte = CMD_HEAD;
				4'd2:       cur_byte = SET_LEN;
				4'd3:       cur_byte = CMD_ADDR;
				4'd4:       cur_byte = SET_OP;
				4'd5:       cur_byte = param_q[31:24];
				4'd6:       cur_byte = param_q[23:16];
				4'd7:       cur_byte = param_q[15:8];
				4'd8:       cur_byte = param_q[7:0];
				default:    cur_byte = sum;
			endcase
		end else begin
			case (byte_idx)
				4'd0, 4'd1: cur_byte = CMD_HEAD;
				4'd2:       cur_byte = READ_LEN;
				4'd3:       cur_byte = CMD_ADDR;
				4'd4:       cur_byte = READ_OP;
				default:    cur_byte = READ_CHK;
			endcase
		end
	end

	assign last = (kind_q == CMD_SET) ? byte_idx == 4'd9 : byte_idx == 4'd5;

endmodule

//--- uart_link_ctrl.sv
module uart_link_ctrl (
	input  logic                          AXI_CLK,
	input  logic                          axi_arstn,
	input  logic                          download_valid,
	input  uart_bridge_pkg::reg_index_t   download_index,
	input  uart_bridge_pkg::word_t        download_data,
	input  logic                          uart_irq,
	output logic                          issue,
	output uart_bridge_pkg::bus_req_t     issue_req,
	input  logic                          can_issue,
	input  logic                          rsp_valid,
	input  uart_bridge_pkg::word_t        rsp_data,
	output logic                          frame_start,
	output uart_bridge_pkg::cmd_kind_t    frame_kind,
	output uart_bridge_pkg::word_t        frame_param,
	output logic                          byte_next,
	input  uart_bridge_pkg::byte_t        cur_byte,
	input  logic                          last,
	output logic                          rx_byte_valid,
	output uart_bridge_pkg::byte_t        rx_byte
);
	import uart_bridge_pkg::*;

	link_state_t state;
	logic        rd_wait;
	logic        taken;
	logic        rsp_hit;
	logic        cmd_pending;
	logic        frame_active;
	logic        set_hit;
	logic        read_hit;

	assign taken   = issue & can_issue;
	assign rsp_hit = rsp_valid & rd_wait;

	// --------------------
	// Host command decode
	// --------------------
	// New commands are dropped while one is pending or on the wire
	assign set_hit  = download_valid && download_index == IDX_SET_PARAM;
	assign read_hit = download_valid && download_index == IDX_READ_PARAM &&
		download_data == READ_PARAM_KEY;

	always_ff @(posedge AXI_CLK or negedge axi_arstn) begin
		if (!axi_arstn) begin
			cmd_pending <= 1'b0;
			frame_kind  <= CMD_READ;
		end else if (frame_start) begin
			cmd_pending <= 1'b0;
		end else if (!cmd_pending && !frame_active && (set_hit || read_hit)) begin
			cmd_pending <= 1'b1;
			frame_kind  <= set_hit ? CMD_SET : CMD_READ;
		end
	end

	always_ff @(posedge AXI_CLK) begin
		if (!cmd_pending && !frame_active && set_hit)
			frame_param <= download_data;
	end

	// Receive service wins over starting a new frame
	assign frame_start = state == LINK_IDLE && !uart_irq && cmd_pending;
	assign byte_next   = state == LINK_TX_WRITE && taken;

	assign rx_byte_valid = state == LINK_RX_DATA && rsp_hit;
	assign rx_byte       = rsp_data[7:0];

	// --------------------
	// Request offer
	// --------------------
	always_comb begin
		issue              = 1'b0;
		issue_req.is_write = 1'b0;
		issue_req.addr     = STAT_REG;
		issue_req.data     = '0;
		case (state)
			LINK_INIT: begin
				issue              = 1'b1;
				issue_req.is_write = 1'b1;
				issue_req.addr     = CTRL_REG;
				issue_req.data     = CMD_INIT;
			end
			LINK_RX_STAT, LINK_TX_STAT: begin
				issue = !rd_wait;
			end
			LINK_RX_DATA: begin
				issue          = !rd_wait;
				issue_req.addr = RX_REG;
			end
			LINK_TX_WRITE: begin
				issue              = 1'b1;
				issue_req.is_write = 1'b1;
				issue_req.addr     = TX_REG;
				issue_req.data     = word_t'(cur_byte);
			end
			default: ;
		endcase
	end

	// --------------------
	// Link FSM
	// --------------------
	always_ff @(posedge AXI_CLK or negedge axi_arstn) begin
		if (!axi_arstn) begin
			state        <= LINK_INIT;
			rd_wait      <= 1'b0;
			frame_active <= 1'b0;
		end else begin
			// One read in flight at most
			if (taken && !issue_req.is_write)
				rd_wait <= 1'b1;
			else if (rsp_hit)
				rd_wait <= 1'b0;

			if (frame_start)
				frame_active <= 1'b1;
			else if (byte_next && last)
				frame_active <= 1'b0;

			case (state)
				LINK_INIT: begin
					if (taken)
						state <= LINK_IDLE;
				end
				LINK_IDLE: begin
					if (uart_irq)
						state <= LINK_RX_STAT;
					else if (frame_active || frame_start)
						state <= LINK_TX_STAT;
				end
				LINK_RX_STAT: begin
					if (rsp_hit)
						state <= rsp_data[STAT_RX_VALID] ? LINK_RX_DATA : LINK_IDLE;
				end
				LINK_RX_DATA: begin
					// Keep draining until status shows the FIFO empty
					if (rsp_hit)
						state <= LINK_RX_STAT;
				end
				LINK_TX_STAT: begin
					// Full FIFO goes back through idle and rereads status
					if (rsp_hit)
						state <= rsp_data[STAT_TX_FULL] ? LINK_IDLE : LINK_TX_WRITE;
				end
				LINK_TX_WRITE: begin
					if (taken)
						state <= LINK_IDLE;
				end
				default: state <= LINK_IDLE;
			endcase
		end
	end

	a_rsp_expected: assert property (@(posedge AXI_CLK) disable iff (!axi_arstn)
		rsp_valid |-> rd_wait);

	a_one_frame: assert property (@(posedge AXI_CLK) disable iff (!axi_arstn)
		frame_start |-> !frame_active);

endmodule

//--- uart_bridge_pkg.sv
package uart_bridge_pkg;

	// --------------------
	// Widths
	// --------------------
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_addr_t;
	typedef logic [3:0]  reg_index_t;
	typedef logic [15:0] param_t;
	typedef logic [1:0]  credit_t;

	// --------------------
	// UART register map
	// --------------------
	localparam reg_addr_t RX_REG   = 4'h0;
	localparam reg_addr_t TX_REG   = 4'h4;
	localparam reg_addr_t STAT_REG = 4'h8;
	localparam reg_addr_t CTRL_REG = 4'hc;

	localparam int STAT_RX_VALID = 0;
	localparam int STAT_TX_FULL  = 3;

	// Reset both FIFOs and enable the interrupt
	localparam word_t CMD_INIT = 32'h0000_0013;

	localparam credit_t CREDIT_MAX = 2'd2;

	// Host side
	localparam word_t      READ_PARAM_KEY = 32'hAAAA_AAAA;
	localparam reg_index_t IDX_SET_PARAM  = 4'd1;
	localparam reg_index_t IDX_READ_PARAM = 4'd2;

	// Command frame bytes toward the amplifier
	localparam byte_t CMD_HEAD  = 8'hEF;
	localparam byte_t CMD_ADDR  = 8'hFF;
	localparam byte_t SET_LEN   = 8'h07;
	localparam byte_t SET_OP    = 8'h40;
	localparam byte_t READ_LEN  = 8'h03;
	localparam byte_t READ_OP   = 8'h00;
	localparam byte_t READ_CHK  = 8'hE0;

	// Parameter frames from the amplifier
	localparam byte_t FRAME_SYNC0      = 8'hED;
	localparam byte_t FRAME_SYNC1      = 8'hFA;
	localparam byte_t FRAME_PARAM_TYPE = 8'h39;

	localparam byte_t RAMAN1_POS   = 8'd8;
	localparam byte_t RAMAN2_POS   = 8'd10;
	localparam byte_t EDFA_POS     = 8'd28;
	localparam byte_t PAYLOAD_LAST = 8'd30;

	localparam reg_index_t UP_RAMAN1 = 4'd1;
	localparam reg_index_t UP_RAMAN2 = 4'd2;
	localparam reg_index_t UP_EDFA   = 4'd3;

	typedef enum logic {
		CMD_SET,
		CMD_READ
	} cmd_kind_t;

	typedef struct packed {
		logic      is_write;
		reg_addr_t addr;
		word_t     data;
	} bus_req_t;

	typedef enum logic [2:0] {
		LINK_INIT,
		LINK_IDLE,
		LINK_RX_STAT,
		LINK_RX_DATA,
		LINK_TX_STAT,
		LINK_TX_WRITE
	} link_state_t;

	typedef enum logic [1:0] {
		PARSE_HUNT,
		PARSE_SYNC,
		PARSE_TYPE,
		PARSE_PAYLOAD
	} parse_state_t;

endpackage
